// File: ooo_wb.f
+incdir+verilog
verilog/ooo_wb_pkg.sv
verilog/reg_file.sv
verilog/issue_ctrl.sv
verilog/exec_pipe.sv
verilog/reorder_buffer.sv
verilog/ooo_wb_top.sv
dv/ooo_wb_tb.sv

// File: Makefile
TOP := ooo_wb_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --top-module $(TOP) -f ooo_wb.f -Mdir obj_dir -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

clean:
	rm -rf obj_dir

// File: dv/ooo_wb_tb.sv
/*
 * ooo_wb testbench
 * Table-driven instruction stream, reference register model, commit checker
 */

`timescale 1ns/1ps
`include "ooo_wb_config.svh"

module ooo_wb_tb
  import ooo_wb_pkg::*;
();

  localparam int XLEN    = `OOO_WB_XLEN;
  localparam int REG_W   = $clog2(`OOO_WB_NREGS);
  localparam int TAG_W   = $clog2(`OOO_WB_ROB_DEPTH);
  localparam int TIMEOUT = 200;
  localparam int NTAB    = 32;

  logic             clk;
  logic             rst;
  logic             instr_valid;
  instr_word_t      instr;
  logic             instr_ready;
  logic             commit_valid;
  logic             commit_ready;
  logic [TAG_W-1:0] commit_tag;
  logic [REG_W-1:0] commit_rd;
  logic [XLEN-1:0]  commit_data;

  // ----------------------------------------
  // Stimulus table and reference state
  // ----------------------------------------
  instr_word_t      tab_word [NTAB];
  logic [1:0]       tab_op   [NTAB];
  int               tab_grp  [NTAB];
  int               n_tab;
  string            test_name [1:6];

  logic [XLEN-1:0]  model_regs [`OOO_WB_NREGS];
  logic [TAG_W-1:0] exp_tag_q  [$];
  logic [REG_W-1:0] exp_rd_q   [$];
  logic [XLEN-1:0]  exp_data_q [$];
  int               issued;

  int               errors;
  int               checks;
  int               errors_at_start;
  int               tests_run;
  int               tests_passed;
  bit               timed_out;
  // 0 always ready, 1 random, 2 held low
  int               bp_mode;
  int               seed;
  logic [31:0]      rnd_word;

  ooo_wb_top ooo_wb_top_i (
    .clk          (clk),
    .rst          (rst),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .instr_ready  (instr_ready),
    .commit_valid (commit_valid),
    .commit_ready (commit_ready),
    .commit_tag   (commit_tag),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // Commit back-pressure driven just after the rising edge
  initial begin
    commit_ready = 1'b1;
    forever begin
      @(posedge clk);
      #10;
      if (bp_mode == 1) begin
        rnd_word     = $random(seed);
        commit_ready = rnd_word[0];
      end else begin
        commit_ready = (bp_mode == 0);
      end
    end
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      $display("CHECK FAILED at %0d ns: %s got 0x%0h, expected 0x%0h", $time, name, got, exp);
      errors++;
    end
  endtask

  // 8-bit two's complement immediate as a full-width value
  function automatic logic [XLEN-1:0] widen_imm(input logic [7:0] imm);
    int v;
    v = imm[7] ? int'(imm) - 256 : int'(imm);
    return XLEN'(v);
  endfunction

  task automatic add_r(input int grp, input logic [1:0] op, input logic [REG_W-1:0] rd,
                       input logic [REG_W-1:0] rs1, input logic [REG_W-1:0] rs2);
    instr_word_t w;
    w            = '0;
    w.r_form.op  = op;
    w.r_form.rd  = rd;
    w.r_form.rs1 = rs1;
    w.r_form.rs2 = rs2;
    tab_word[n_tab] = w;
    tab_op[n_tab]   = op;
    tab_grp[n_tab]  = grp;
    n_tab++;
  endtask

  task automatic add_i(input int grp, input logic [REG_W-1:0] rd,
                       input logic [REG_W-1:0] rs1, input logic [7:0] imm);
    instr_word_t w;
    w            = '0;
    w.i_form.op  = OP_ADDI;
    w.i_form.rd  = rd;
    w.i_form.rs1 = rs1;
    w.i_form.imm = imm;
    tab_word[n_tab] = w;
    tab_op[n_tab]   = OP_ADDI;
    tab_grp[n_tab]  = grp;
    n_tab++;
  endtask

  // Holds valid until accepted, then updates the model in program order
  task automatic send_instr(input instr_word_t word, input logic [1:0] op);
    int              waited;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] res;
    waited      = 0;
    instr       = word;
    instr_valid = 1'b1;
    @(negedge clk);
    while (!instr_ready && !timed_out) begin
      waited++;
      if (waited > TIMEOUT) begin
        $display("TIMEOUT at %0d ns: instruction 0x%04h was never accepted", $time, word);
        timed_out = 1'b1;
        errors++;
      end else begin
        @(negedge clk);
      end
    end
    if (!timed_out) begin
      a = model_regs[word.r_form.rs1];
      b = (op == OP_ADDI) ? widen_imm(word.i_form.imm) : model_regs[word.r_form.rs2];
      case (op)
        OP_SUB:  res = a - b;
        OP_MUL:  res = a * b;
        default: res = a + b;
      endcase
      model_regs[word.r_form.rd] = res;
      exp_tag_q.push_back(TAG_W'(issued % `OOO_WB_ROB_DEPTH));
      exp_rd_q.push_back(word.r_form.rd);
      exp_data_q.push_back(res);
      issued++;
    end
    @(posedge clk);
    #10;
    instr_valid = 1'b0;
  endtask

  task automatic drain_commits();
    int waited;
    waited = 0;
    while (exp_data_q.size() != 0 && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > TIMEOUT) begin
        $display("TIMEOUT at %0d ns: %0d results were never committed", $time,
                 exp_data_q.size());
        timed_out = 1'b1;
        errors++;
      end
    end
    @(posedge clk);
    #10;
  endtask

  task automatic start_test(input int grp);
    errors_at_start = errors;
    bp_mode = (grp == 5) ? 1 : (grp == 6) ? 2 : 0;
  endtask

  task automatic finish_test(input int grp);
    tests_run++;
    if (errors == errors_at_start)
      tests_passed++;
    $display("test %0d %-20s %s (%0d errors)", grp, test_name[grp],
             (errors == errors_at_start) ? "PASS" : "FAIL", errors - errors_at_start);
  endtask

  // Four live ops with commit blocked leave the fifth stalled until a retire
  task automatic hold_test(input int first);
    for (int k = 0; k < 4; k++)
      send_instr(tab_word[first + k], tab_op[first + k]);
    instr       = tab_word[first + 4];
    instr_valid = 1'b1;
    for (int k = 0; k < 8; k++) begin
      @(negedge clk);
      check_value("instr_ready", 32'(instr_ready), 32'd0);
    end
    @(posedge clk);
    #10;
    bp_mode = 0;
    send_instr(tab_word[first + 4], tab_op[first + 4]);
  endtask

  // ----------------------------------------
  // Commit monitor
  // ----------------------------------------
  initial begin
    bit held;
    held = 1'b0;
    forever begin
      @(negedge clk);
      if (rst) begin
        held = 1'b0;
      end else begin
        // A result refused last cycle must still be offered
        if (held)
          check_value("commit_valid", 32'(commit_valid), 32'd1);
        if (commit_valid) begin
          if (exp_data_q.size() == 0) begin
            $display("ERROR at %0d ns: tag %0d offered with nothing outstanding", $time,
                     commit_tag);
            errors++;
          end else begin
            // Oldest outstanding result, whether or not it retires now
            check_value("commit_tag", 32'(commit_tag), 32'(exp_tag_q[0]));
            check_value("commit_rd", 32'(commit_rd), 32'(exp_rd_q[0]));
            check_value("commit_data", 32'(commit_data), 32'(exp_data_q[0]));
            if (commit_ready) begin
              exp_tag_q.delete(0);
              exp_rd_q.delete(0);
              exp_data_q.delete(0);
            end
          end
        end
        held = commit_valid & ~commit_ready;
      end
    end
  end

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    int i;
    int grp;
    rst         = 1'b1;
    instr_valid = 1'b0;
    instr       = '0;
    bp_mode     = 0;
    seed        = 32'hba4a229c;
    errors      = 0;
    checks      = 0;
    issued      = 0;
    n_tab       = 0;
    timed_out   = 1'b0;
    tests_run    = 0;
    tests_passed = 0;
    for (int r = 0; r < `OOO_WB_NREGS; r++)
      model_regs[r] = '0;

    test_name[1] = "addi_sign_extend";
    test_name[2] = "alu_independent";
    test_name[3] = "mul_then_alu";
    test_name[4] = "dependency_chain";
    test_name[5] = "random_backpressure";
    test_name[6] = "commit_hold_stall";

    // Register loads including negative immediates
    add_i(1, 3'd1, 3'd0, 8'h7f);
    add_i(1, 3'd2, 3'd0, 8'h80);
    add_i(1, 3'd3, 3'd1, 8'hff);
    add_i(1, 3'd4, 3'd2, 8'h81);
    add_i(1, 3'd5, 3'd0, 8'h05);
    // Independent ops with wrapping results
    add_r(2, OP_ADD, 3'd6, 3'd1, 3'd2);
    add_r(2, OP_SUB, 3'd7, 3'd0, 3'd1);
    add_r(2, OP_ADD, 3'd3, 3'd4, 3'd4);
    // Slow multiply ahead of fast ALU ops
    add_r(3, OP_MUL, 3'd1, 3'd5, 3'd4);
    add_r(3, OP_ADD, 3'd2, 3'd5, 3'd5);
    add_r(3, OP_SUB, 3'd6, 3'd7, 3'd5);
    add_i(3, 3'd0, 3'd5, 8'h01);
    // RAW and WAW on r3 and r4
    add_r(4, OP_ADD, 3'd3, 3'd1, 3'd2);
    add_r(4, OP_MUL, 3'd3, 3'd3, 3'd2);
    add_r(4, OP_SUB, 3'd4, 3'd3, 3'd0);
    add_i(4, 3'd4, 3'd4, 8'hf0);
    add_r(4, OP_ADD, 3'd5, 3'd4, 3'd3);
    // Mixed stream under random commit_ready
    add_r(5, OP_MUL, 3'd1, 3'd6, 3'd7);
    add_i(5, 3'd2, 3'd0, 8'h9c);
    add_r(5, OP_ADD, 3'd3, 3'd2, 3'd5);
    add_r(5, OP_SUB, 3'd4, 3'd1, 3'd3);
    add_r(5, OP_MUL, 3'd6, 3'd4, 3'd4);
    add_i(5, 3'd7, 3'd7, 8'h01);
    add_r(5, OP_ADD, 3'd0, 3'd6, 3'd7);
    add_r(5, OP_SUB, 3'd5, 3'd5, 3'd2);
    // Four independent ops and a fifth free of register hazards
    add_i(6, 3'd1, 3'd0, 8'h11);
    add_i(6, 3'd2, 3'd0, 8'h22);
    add_r(6, OP_ADD, 3'd3, 3'd5, 3'd6);
    add_r(6, OP_SUB, 3'd4, 3'd7, 3'd0);
    add_r(6, OP_ADD, 3'd5, 3'd6, 3'd7);

    repeat (4) @(posedge clk);
    #10;
    rst = 1'b0;

    i = 0;
    while (i < n_tab && !timed_out) begin
      grp = tab_grp[i];
      start_test(grp);
      if (grp == 6) begin
        hold_test(i);
        i = i + 5;
      end else begin
        while (i < n_tab && tab_grp[i] == grp && !timed_out) begin
          send_instr(tab_word[i], tab_op[i]);
          i++;
        end
      end
      drain_commits();
      finish_test(grp);
    end

    $display("%0d tests, %0d passed, %0d checks, %0d errors", tests_run, tests_passed,
             checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: verilog/ooo_wb_top.sv
/*
 * ooo_wb top level
 * In-order issue, out-of-order completion, in-order commit through a ROB
 */

`timescale 1ns/1ps
`include "ooo_wb_config.svh"

module ooo_wb_top
  import ooo_wb_pkg::*;
(
  input  logic                                 clk,
  input  logic                                 rst,
  // Instruction input
  input  logic                                 instr_valid,
  input  instr_word_t                          instr,
  output logic                                 instr_ready,
  // Commit port
  output logic                                 commit_valid,
  input  logic                                 commit_ready,
  output logic [$clog2(`OOO_WB_ROB_DEPTH)-1:0] commit_tag,
  output logic [$clog2(`OOO_WB_NREGS)-1:0]     commit_rd,
  output logic [`OOO_WB_XLEN-1:0]              commit_data
);

  localparam int XLEN  = `OOO_WB_XLEN;
  localparam int REG_W = $clog2(`OOO_WB_NREGS);
  localparam int TAG_W = $clog2(`OOO_WB_ROB_DEPTH);
  localparam int MSG_W = REG_W + XLEN;

  // ----------------------------------------
  // Interconnect
  // ----------------------------------------
  logic [REG_W-1:0] rs1_addr;
  logic [REG_W-1:0] rs2_addr;
  logic [XLEN-1:0]  rs1_data;
  logic [XLEN-1:0]  rs2_data;

  logic             issue_valid;
  logic [1:0]       issue_op;
  logic [TAG_W-1:0] issue_tag;
  logic [REG_W-1:0] issue_rd;
  logic [XLEN-1:0]  issue_a;
  logic [XLEN-1:0]  issue_b;

  logic             ins_en;
  logic [TAG_W-1:0] ins_idx;
  logic [MSG_W-1:0] ins_msg;
  logic [MSG_W-1:0] deq_msg;
  logic             commit_fire;

  // Message layout is {rd, result}
  assign commit_rd   = deq_msg[MSG_W-1 -: REG_W];
  assign commit_data = deq_msg[XLEN-1:0];
  assign commit_fire = commit_valid & commit_ready;

  issue_ctrl issue_ctrl_i (
    .clk         (clk),
    .rst         (rst),
    .instr_valid (instr_valid),
    .instr       (instr),
    .instr_ready (instr_ready),
    .rs1_addr    (rs1_addr),
    .rs2_addr    (rs2_addr),
    .rs1_data    (rs1_data),
    .rs2_data    (rs2_data),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_tag   (issue_tag),
    .issue_rd    (issue_rd),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .commit_fire (commit_fire),
    .commit_rd   (commit_rd)
  );

  exec_pipe exec_pipe_i (
    .clk         (clk),
    .rst         (rst),
    .issue_valid (issue_valid),
    .issue_op    (issue_op),
    .issue_tag   (issue_tag),
    .issue_rd    (issue_rd),
    .issue_a     (issue_a),
    .issue_b     (issue_b),
    .ins_en      (ins_en),
    .ins_idx     (ins_idx),
    .ins_msg     (ins_msg)
  );

  // Dequeue side is the commit port itself
  reorder_buffer #(
    .DEPTH (`OOO_WB_ROB_DEPTH),
    .MSG_W (MSG_W)
  ) reorder_buffer_i (
    .clk     (clk),
    .rst     (rst),
    .ins_idx (ins_idx),
    .ins_msg (ins_msg),
    .ins_en  (ins_en),
    .deq_idx (commit_tag),
    .deq_msg (deq_msg),
    .deq_en  (commit_ready),
    .deq_rdy (commit_valid)
  );

  reg_file reg_file_i (
    .clk       (clk),
    .rst       (rst),
    .rd_addr_a (rs1_addr),
    .rd_addr_b (rs2_addr),
    .rd_data_a (rs1_data),
    .rd_data_b (rs2_data),
    .wr_en     (commit_fire),
    .wr_addr   (commit_rd),
    .wr_data   (commit_data)
  );

endmodule

// File: verilog/reorder_buffer.sv
/*
 * Reorder buffer
 * Results land by tag, retire in order, insert at the head bypasses
 */

`timescale 1ns/1ps

module reorder_buffer #(
  parameter int DEPTH = 4,
  parameter int MSG_W = 19
) (
  input  logic                     clk,
  input  logic                     rst,

  // ----------------------------------------
  // Insert side
  // ----------------------------------------
  input  logic [$clog2(DEPTH)-1:0] ins_idx,
  input  logic [MSG_W-1:0]         ins_msg,
  input  logic                     ins_en,

  // ----------------------------------------
  // Dequeue side
  // ----------------------------------------
  output logic [$clog2(DEPTH)-1:0] deq_idx,
  output logic [MSG_W-1:0]         deq_msg,
  input  logic                     deq_en,
  output logic                     deq_rdy
);

  localparam int IDX_W = $clog2(DEPTH);

  // Payload storage and per-entry valid
  logic [MSG_W-1:0] msg_mem [DEPTH];
  logic [DEPTH-1:0] val;

  logic [IDX_W-1:0] deq_ptr;
  logic             head_val;
  logic             head_hit;
  logic             retire;
  logic             bypass_taken;

  assign head_val = val[deq_ptr];
  // Fresh result for the head entry, shown before it is stored
  assign head_hit = ins_en & (ins_idx == deq_ptr) & ~head_val;

  assign deq_rdy = head_val | head_hit;
  assign deq_msg = head_hit ? ins_msg : msg_mem[deq_ptr];
  assign deq_idx = deq_ptr;

  assign retire       = deq_en & deq_rdy;
  // Retired straight from the insert port, so no write needed
  assign bypass_taken = head_hit & deq_en;

  // ----------------------------------------
  // Entry update
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      val <= '0;
    end else begin
      if (ins_en & ~bypass_taken)
        val[ins_idx] <= 1'b1;
      if (retire & head_val)
        val[deq_ptr] <= 1'b0;
    end
  end

  // Unretired bypass gets stored, so the head stays stable
  always_ff @(posedge clk) begin
    if (ins_en & ~bypass_taken)
      msg_mem[ins_idx] <= ins_msg;
  end

  // ----------------------------------------
  // Retire pointer
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst)
      deq_ptr <= '0;
    else if (retire) begin
      if (deq_ptr == IDX_W'(DEPTH - 1))
        deq_ptr <= '0;
      else
        deq_ptr <= deq_ptr + 1'b1;
    end
  end

endmodule

// File: verilog/exec_pipe.sv
/*
 * Execution paths
 * One-cycle ALU and pipelined multiplier sharing one completion port
 */

`timescale 1ns/1ps
`include "ooo_wb_config.svh"

module exec_pipe
  import ooo_wb_pkg::*;
(
  input  logic                                                      clk,
  input  logic                                                      rst,
  // From issue
  input  logic                                                      issue_valid,
  input  logic [1:0]                                                issue_op,
  input  logic [$clog2(`OOO_WB_ROB_DEPTH)-1:0]                      issue_tag,
  input  logic [$clog2(`OOO_WB_NREGS)-1:0]                          issue_rd,
  input  logic [`OOO_WB_XLEN-1:0]                                   issue_a,
  input  logic [`OOO_WB_XLEN-1:0]                                   issue_b,
  // Completion into the reorder buffer
  output logic                                                      ins_en,
  output logic [$clog2(`OOO_WB_ROB_DEPTH)-1:0]                      ins_idx,
  output logic [$clog2(`OOO_WB_NREGS)+`OOO_WB_XLEN-1:0]             ins_msg
);

  localparam int XLEN  = `OOO_WB_XLEN;
  localparam int REG_W = $clog2(`OOO_WB_NREGS);
  localparam int TAG_W = $clog2(`OOO_WB_ROB_DEPTH);
  localparam int LAT   = `OOO_WB_MUL_LAT;

  logic is_mul;
  assign is_mul = (issue_op == OP_MUL);

  // ----------------------------------------
  // ALU path
  // ----------------------------------------
  logic             alu_vld;
  logic [TAG_W-1:0] alu_tag;
  logic [REG_W-1:0] alu_rd;
  logic [XLEN-1:0]  alu_res;

  always_ff @(posedge clk) begin
    if (rst)
      alu_vld <= 1'b0;
    else
      alu_vld <= issue_valid & ~is_mul;
  end

  // ADDI carries its immediate in issue_b, so it adds too
  always_ff @(posedge clk) begin
    alu_tag <= issue_tag;
    alu_rd  <= issue_rd;
    if (issue_op == OP_SUB)
      alu_res <= issue_a - issue_b;
    else
      alu_res <= issue_a + issue_b;
  end

  // ----------------------------------------
  // Multiplier pipeline
  // ----------------------------------------
  logic [LAT-1:0]   mul_vld;
  logic [TAG_W-1:0] mul_tag  [LAT];
  logic [REG_W-1:0] mul_rd   [LAT];
  logic [XLEN-1:0]  mul_prod [LAT];

  always_ff @(posedge clk) begin
    if (rst)
      mul_vld <= '0;
    else
      mul_vld <= {mul_vld[LAT-2:0], issue_valid & is_mul};
  end

  // Stage 0 forms the low half of the product, later stages only delay
  always_ff @(posedge clk) begin
    mul_tag[0]  <= issue_tag;
    mul_rd[0]   <= issue_rd;
    mul_prod[0] <= issue_a * issue_b;
    for (int s = 1; s < LAT; s++) begin
      mul_tag[s]  <= mul_tag[s-1];
      mul_rd[s]   <= mul_rd[s-1];
      mul_prod[s] <= mul_prod[s-1];
    end
  end

  // ----------------------------------------
  // Completion merge
  // ----------------------------------------
  // Issue never lets both paths finish together
  assign ins_en  = alu_vld | mul_vld[LAT-1];
  assign ins_idx = mul_vld[LAT-1] ? mul_tag[LAT-1] : alu_tag;
  assign ins_msg = mul_vld[LAT-1] ? {mul_rd[LAT-1], mul_prod[LAT-1]} : {alu_rd, alu_res};

endmodule

// File: verilog/issue_ctrl.sv
/*
 * In-order issue control
 * Decodes, tracks register and buffer hazards, hands out tags, issues
 */

`timescale 1ns/1ps
`include "ooo_wb_config.svh"

module issue_ctrl
  import ooo_wb_pkg::*;
(
  input  logic                                   clk,
  input  logic                                   rst,
  // Instruction input
  input  logic                                   instr_valid,
  input  instr_word_t                            instr,
  output logic                                   instr_ready,
  // Register file read ports
  output logic [$clog2(`OOO_WB_NREGS)-1:0]       rs1_addr,
  output logic [$clog2(`OOO_WB_NREGS)-1:0]       rs2_addr,
  input  logic [`OOO_WB_XLEN-1:0]                rs1_data,
  input  logic [`OOO_WB_XLEN-1:0]                rs2_data,
  // Issue to execution
  output logic                                   issue_valid,
  output logic [1:0]                             issue_op,
  output logic [$clog2(`OOO_WB_ROB_DEPTH)-1:0]   issue_tag,
  output logic [$clog2(`OOO_WB_NREGS)-1:0]       issue_rd,
  output logic [`OOO_WB_XLEN-1:0]                issue_a,
  output logic [`OOO_WB_XLEN-1:0]                issue_b,
  // Retire feedback
  input  logic                                   commit_fire,
  input  logic [$clog2(`OOO_WB_NREGS)-1:0]       commit_rd
);

  localparam int DEPTH = `OOO_WB_ROB_DEPTH;
  localparam int REG_W = $clog2(`OOO_WB_NREGS);
  localparam int TAG_W = $clog2(DEPTH);
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam int LAT   = `OOO_WB_MUL_LAT;

  logic [`OOO_WB_NREGS-1:0] pending;
  logic [`OOO_WB_NREGS-1:0] pending_nxt;
  logic [CNT_W-1:0]         inflight;
  logic [CNT_W-1:0]         inflight_nxt;
  logic [TAG_W-1:0]         tag_ctr;
  logic [LAT-2:0]           mul_hist;
  logic                     started;

  logic [1:0]       op;
  logic [REG_W-1:0] rd;
  logic             uses_rs2;
  logic             is_mul;
  logic             reg_hazard;
  logic             rob_full;
  logic             port_clash;
  logic             fire;

  // ----------------------------------------
  // Decode
  // ----------------------------------------
  // op, rd and rs1 sit at the same bits in both views
  assign op       = instr.r_form.op;
  assign rd       = instr.r_form.rd;
  assign rs1_addr = instr.r_form.rs1;
  assign rs2_addr = instr.r_form.rs2;
  assign uses_rs2 = (op != OP_ADDI);
  assign is_mul   = (op == OP_MUL);

  // ----------------------------------------
  // Stall decision
  // ----------------------------------------
  // RAW on either source, WAW on rd
  assign reg_hazard = pending[rs1_addr] | (uses_rs2 & pending[rs2_addr]) | pending[rd];
  // Every tag still owned by an uncommitted op
  assign rob_full   = (inflight == CNT_W'(DEPTH));
  // ALU result would land with a multiply from LAT-1 cycles back
  assign port_clash = ~is_mul & mul_hist[LAT-2];

  assign instr_ready = started & ~rob_full & ~reg_hazard & ~port_clash;
  assign fire        = instr_valid & instr_ready;

  // Issue is combinational in the accept cycle
  assign issue_valid = fire;
  assign issue_op    = op;
  assign issue_tag   = tag_ctr;
  assign issue_rd    = rd;
  assign issue_a     = rs1_data;
  assign issue_b     = uses_rs2 ? rs2_data : sext_imm(instr.i_form.imm);

  // ----------------------------------------
  // Bookkeeping
  // ----------------------------------------
  always_comb begin
    pending_nxt = pending;
    // Only one writer per register can be live, so no set/clear overlap
    if (commit_fire)
      pending_nxt[commit_rd] = 1'b0;
    if (fire)
      pending_nxt[rd] = 1'b1;
  end

  always_comb begin
    case ({fire, commit_fire})
      2'b10:   inflight_nxt = inflight + 1'b1;
      2'b01:   inflight_nxt = inflight - 1'b1;
      default: inflight_nxt = inflight;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pending  <= '0;
      inflight <= '0;
      tag_ctr  <= '0;
      mul_hist <= '0;
      started  <= 1'b0;
    end else begin
      pending  <= pending_nxt;
      inflight <= inflight_nxt;
      // Holds ready low for one cycle after reset
      started  <= 1'b1;
      // Bit k set means a multiply went out k+1 cycles ago
      mul_hist <= (mul_hist << 1) | (LAT-1)'(fire & is_mul);
      if (fire) begin
        if (tag_ctr == TAG_W'(DEPTH - 1))
          tag_ctr <= '0;
        else
          tag_ctr <= tag_ctr + 1'b1;
      end
    end
  end

endmodule

// File: verilog/reg_file.sv
/*
 * Architectural register file
 * Two combinational reads, one write at retire
 */

`timescale 1ns/1ps
`include "ooo_wb_config.svh"

module reg_file (
  input  logic                             clk,
  input  logic                             rst,
  // Read ports
  input  logic [$clog2(`OOO_WB_NREGS)-1:0] rd_addr_a,
  input  logic [$clog2(`OOO_WB_NREGS)-1:0] rd_addr_b,
  output logic [`OOO_WB_XLEN-1:0]          rd_data_a,
  output logic [`OOO_WB_XLEN-1:0]          rd_data_b,
  // Write port, driven by retire
  input  logic                             wr_en,
  input  logic [$clog2(`OOO_WB_NREGS)-1:0] wr_addr,
  input  logic [`OOO_WB_XLEN-1:0]          wr_data
);

  logic [`OOO_WB_XLEN-1:0] regs [`OOO_WB_NREGS];

  // All registers start at zero
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `OOO_WB_NREGS; i++)
        regs[i] <= '0;
    end else if (wr_en) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // New value seen the cycle after the write
  assign rd_data_a = regs[rd_addr_a];
  assign rd_data_b = regs[rd_addr_b];

endmodule

// File: verilog/ooo_wb_pkg.sv
/*
 * ooo_wb shared types
 * Instruction word with register and immediate views, opcode values
 */

`include "ooo_wb_config.svh"

package ooo_wb_pkg;

  // ----------------------------------------
  // Opcodes
  // ----------------------------------------
  localparam logic [1:0] OP_ADD  = 2'd0;
  localparam logic [1:0] OP_SUB  = 2'd1;
  localparam logic [1:0] OP_MUL  = 2'd2;
  // Only opcode using the immediate view
  localparam logic [1:0] OP_ADDI = 2'd3;

  // ----------------------------------------
  // Instruction word
  // ----------------------------------------
  typedef union packed {
    // Register form for ADD, SUB, MUL
    struct packed {
      logic [1:0] op;
      logic [2:0] rd;
      logic [2:0] rs1;
      logic [2:0] rs2;
      logic [4:0] pad;
    } r_form;
    // Immediate form for ADDI, imm overlays rs2 and pad
    struct packed {
      logic [1:0]        op;
      logic [2:0]        rd;
      logic [2:0]        rs1;
      logic signed [7:0] imm;
    } i_form;
  } instr_word_t;

  // Widen the 8-bit immediate to a full operand
  function automatic logic [`OOO_WB_XLEN-1:0] sext_imm(input logic signed [7:0] imm);
    return {{(`OOO_WB_XLEN-8){imm[7]}}, imm};
  endfunction

endpackage

// File: verilog/ooo_wb_config.svh
/*
 * ooo_wb configuration
 * Sizes for the datapath, register file, reorder buffer and multiplier
 */

`ifndef OOO_WB_CONFIG_SVH
`define OOO_WB_CONFIG_SVH

// Datapath width in bits
`define OOO_WB_XLEN 16

// Architectural registers, 3-bit index
`define OOO_WB_NREGS 8

// Reorder buffer entries, also the number of live tags
`define OOO_WB_ROB_DEPTH 4

// Multiplier issue to completion, in cycles (2 or more)
`define OOO_WB_MUL_LAT 3

`endif
